/* list.f */
verilog/fq_geom_pkg.sv
verilog/fq_insn_pkg.sv
verilog/fetch_packer.sv
verilog/multi_fifo.sv
verilog/dispatch_ctrl.sv
verilog/fetch_queue.sv
verif/fetch_queue_tb.sv

/* verif/fetch_queue_tb.sv */
/*
 * fetch queue testbench
 * random fetch packets, ready counts and flushes drive the queue.
 * a queue model predicts accept and the dispatch packet each cycle,
 * and a compare process checks the DUT at the falling edge.
 */
module fetch_queue_tb
  import fq_geom_pkg::*;
  import fq_insn_pkg::*;
();

  localparam int RST_CYCLES   = 2;
  localparam int LEN_COMPACT  = 40;
  localparam int LEN_BP_FILL  = 8;
  localparam int LEN_BP_DRAIN = 6;
  localparam int LEN_PARTIAL  = 60;
  localparam int LEN_TAGS     = 50;
  localparam int LEN_FLUSH    = 20;
  localparam int LEN_MIXED    = 400;
  // two resets, six test ends, five cycles of flush setup
  localparam int TOTAL_CYCLES = 2 * (RST_CYCLES + 1) + 6 + 5 + LEN_COMPACT + LEN_BP_FILL
                              + LEN_BP_DRAIN + LEN_PARTIAL + LEN_TAGS + LEN_FLUSH + LEN_MIXED;
  localparam int CYCLE_LIMIT  = 2 * TOTAL_CYCLES;

  logic       clk;
  logic       rst_n;
  logic       flush;
  fetch_pkt_t fetch_in;
  logic       fetch_accept;
  slot_cnt_t  disp_ready_cnt;
  disp_pkt_t  disp_out;

  insn_t       model_q[$];     // oldest entry at the front
  seq_tag_t    model_tag;
  logic        last_accept;    // fetch holds its packet when low
  logic        chk_en;
  integer      seed;
  int          cycles;
  int          checks;
  int          errors;
  int          rejects;        // cycles with accept low
  int          tests_run;
  int          tests_failed;
  int          test_err_start;
  string       test_name;
  logic [11:0] pc_ctr;

  initial clk = 1'b0;
  always #2 clk = ~clk;

  fetch_queue i_fetch_queue (
    .clk            (clk),
    .rst_n          (rst_n),
    .flush          (flush),
    .fetch_in       (fetch_in),
    .fetch_accept   (fetch_accept),
    .disp_ready_cnt (disp_ready_cnt),
    .disp_out       (disp_out)
  );

  function automatic int rnd(input int n);
    return {$random(seed)} % n;
  endfunction

  // expected accept and dispatch packet from the model and current inputs
  function automatic disp_pkt_t model_expect(input fetch_pkt_t pkt, input slot_cnt_t rdy,
                                             input logic fl, output logic acc);
    disp_pkt_t exp;
    int        n;
    int        held;
    int        take;
    n    = $countones(pkt.valid);
    held = model_q.size();
    acc  = !fl && (FQ_DEPTH - held >= n);
    take = (held < FQ_POP_W) ? held : FQ_POP_W;
    if (int'(rdy) < take) take = int'(rdy);
    if (fl) take = 0;
    exp = '0;
    for (int i = 0; i < FQ_POP_W; i++) begin
      exp.tag[i] = model_tag + seq_tag_t'(i);
      if (i < take) begin
        exp.valid[i] = 1'b1;
        exp.insn[i]  = model_q[i];
      end
    end
    return exp;
  endfunction

  task automatic check_accept(input logic exp, input logic act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("** Error [%s] fetch_accept: expected %b, actual %b", test_name, exp, act);
    end
  endtask

  task automatic check_disp(input disp_pkt_t exp, input disp_pkt_t act);
    disp_pkt_t exp_m;
    disp_pkt_t act_m;
    exp_m = exp;
    act_m = act;
    for (int i = 0; i < FQ_POP_W; i++) begin
      if (!exp.valid[i]) begin  // slots not dispatched carry don't-care data
        exp_m.insn[i] = '0;
        exp_m.tag[i]  = '0;
        act_m.insn[i] = '0;
        act_m.tag[i]  = '0;
      end
    end
    checks++;
    if (act_m !== exp_m) begin
      errors++;
      $display("** Error [%s] disp_out: expected %h, actual %h", test_name, exp_m, act_m);
    end
  endtask

  // compare, then advance the model to the state after the next edge
  always @(negedge clk) begin : compare
    disp_pkt_t exp;
    logic      acc;
    int        take;
    if (chk_en) begin
      exp = model_expect(fetch_in, disp_ready_cnt, flush, acc);
      check_accept(acc, fetch_accept);
      check_disp(exp, disp_out);
      take = $countones(exp.valid);
      if (flush) begin
        model_q.delete();
      end else begin
        for (int i = 0; i < take; i++) model_q.delete(0);
        if (acc) begin
          for (int i = 0; i < FQ_PUSH_W; i++) begin
            if (fetch_in.valid[i]) model_q.push_back(fetch_in.slot[i]);
          end
        end
      end
      model_tag   = model_tag + seq_tag_t'(take);  // kept across flush
      last_accept = acc;
      if (!fetch_accept) rejects++;
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles > CYCLE_LIMIT) begin
      $display("timeout after %0d cycles, the tests did not finish", cycles);
      $display("Regression failed");
      $finish;
    end
  end

  // fresh packet; slots outside the mask get junk too
  task automatic make_packet(input logic [FQ_PUSH_W-1:0] mask);
    insn_t ins;
    fetch_in.valid = mask;
    for (int i = 0; i < FQ_PUSH_W; i++) begin
      ins.op    = op_e'(3'(rnd(6)));
      ins.rd    = 5'(rnd(32));
      ins.rs1   = 5'(rnd(32));
      ins.rs2   = 5'(rnd(32));
      ins.imm   = 12'(rnd(4096));
      ins.pc_lo = pc_ctr;
      pc_ctr    = pc_ctr + 12'd4;
      fetch_in.slot[i] = ins;
    end
  endtask

  task automatic step(input logic [FQ_PUSH_W-1:0] mask, input slot_cnt_t rdy,
                      input logic fl);
    @(posedge clk);
    #1;
    if (last_accept) make_packet(mask);  // otherwise hold the rejected packet
    disp_ready_cnt = rdy;
    flush          = fl;
  endtask

  task automatic apply_reset();
    chk_en         = 1'b0;
    rst_n          = 1'b0;
    flush          = 1'b0;
    disp_ready_cnt = '0;
    fetch_in       = '0;
    repeat (RST_CYCLES) @(posedge clk);
    #1;
    rst_n = 1'b1;
    model_q.delete();
    model_tag   = '0;
    last_accept = 1'b1;
    chk_en      = 1'b1;
  endtask

  task automatic begin_test(input string name);
    test_name      = name;
    test_err_start = errors;
    rejects        = 0;
  endtask

  task automatic end_test();
    @(negedge clk);  // last step still gets compared
    #1;
    tests_run++;
    if (errors > test_err_start) begin
      tests_failed++;
      $display("test %-12s FAIL, %0d errors", test_name, errors - test_err_start);
    end else begin
      $display("test %-12s ok", test_name);
    end
  endtask

  initial begin
    seed        = 32'h31b4_5275;
    pc_ctr      = '0;
    rst_n       = 1'b0;
    flush       = 1'b0;
    fetch_in    = '0;
    disp_ready_cnt = '0;
    chk_en      = 1'b0;
    last_accept = 1'b1;
    model_tag   = '0;
    apply_reset();

    begin_test("compaction");
    repeat (LEN_COMPACT) step(4'(rnd(16)), 3'd4, 1'b0);
    end_test();

    begin_test("backpressure");
    repeat (LEN_BP_FILL) step(4'hf, 3'd0, 1'b0);
    repeat (LEN_BP_DRAIN) step(4'h0, 3'd4, 1'b0);  // held packet goes in here
    if (rejects == 0) begin
      errors++;
      $display("[%s] fetch was never held off while the queue was full", test_name);
    end
    end_test();

    begin_test("partial");
    repeat (LEN_PARTIAL) step(4'(rnd(16)), slot_cnt_t'(rnd(5)), 1'b0);
    end_test();

    // tags must restart at 0 after reset
    begin_test("seq_tags");
    apply_reset();
    repeat (LEN_TAGS) step(4'(rnd(16)), slot_cnt_t'(rnd(5)), 1'b0);
    end_test();

    begin_test("flush");
    repeat (4) step(4'hf, 3'd0, 1'b0);
    step(4'(rnd(16)), 3'd4, 1'b1);
    repeat (LEN_FLUSH) step(4'(rnd(16)), 3'd4, 1'b0);
    end_test();

    begin_test("mixed");
    repeat (LEN_MIXED) step(4'(rnd(16)), slot_cnt_t'(rnd(5)), rnd(32) == 0);
    end_test();

    $display("tests %0d, failing %0d, checks %0d, errors %0d",
             tests_run, tests_failed, checks, errors);
    if (errors == 0 && tests_failed == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

/* verilog/dispatch_ctrl.sv */
/*
 * dispatch controller
 * pops min(available, ready) of the oldest entries each cycle and
 * presents them to dispatch with consecutive sequence tags. the tag
 * counter survives a flush.
 */
module dispatch_ctrl
  import fq_geom_pkg::*;
  import fq_insn_pkg::*;
(
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 flush,
  input  slot_cnt_t            disp_ready_cnt,
  input  logic                 empty,
  input  logic [FQ_POP_W-1:1]  almost_empty,
  input  insn_t [FQ_POP_W-1:0] head,
  output logic [FQ_POP_W-1:0]  pop,
  output disp_pkt_t            disp_out
);

  slot_cnt_t avail;     // held entries, capped at 4
  slot_cnt_t pop_cnt;
  seq_tag_t  tag_q;     // tag of the next dispatched slot

  // nested flags, lowest set bit is the exact occupancy
  always_comb begin
    avail = slot_cnt_t'(FQ_POP_W);
    for (int i = FQ_POP_W - 1; i >= 1; i--) begin
      if (almost_empty[i]) avail = slot_cnt_t'(i);
    end
    if (empty) avail = '0;
  end

  always_comb begin
    if (flush) begin
      pop_cnt = '0;  // queue is being dropped
    end else if (avail < disp_ready_cnt) begin
      pop_cnt = avail;
    end else begin
      pop_cnt = disp_ready_cnt;
    end
  end

  always_comb begin
    for (int i = 0; i < FQ_POP_W; i++) begin
      pop[i] = (pop_cnt > slot_cnt_t'(i));
    end
  end

  always_comb begin
    disp_out.valid = pop;
    disp_out.insn  = head;
    for (int i = 0; i < FQ_POP_W; i++) begin
      disp_out.tag[i] = tag_q + seq_tag_t'(i);
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      tag_q <= '0;
    end else begin
      tag_q <= tag_q + seq_tag_t'(pop_cnt);  // wraps mod 64
    end
  end

endmodule

/* verilog/fetch_packer.sv */
/*
 * fetch packer
 * squeezes the valid slots of a fetch packet toward slot 0 in fetch
 * order, and accepts the packet only when the queue has room for all
 * of them. free space comes from the registered FIFO flags.
 */
module fetch_packer
  import fq_geom_pkg::*;
  import fq_insn_pkg::*;
(
  input  fetch_pkt_t            fetch_in,
  input  logic                  flush,
  input  logic                  full,
  input  logic [FQ_PUSH_W-1:1]  almost_full,
  output logic                  fetch_accept,
  output logic [FQ_PUSH_W-1:0]  push,
  output insn_t [FQ_PUSH_W-1:0] push_data
);

  slot_cnt_t             n_valid;
  slot_cnt_t             free_cap;   // free entries, capped at 4
  insn_t [FQ_PUSH_W-1:0] packed_slots;
  logic [FQ_PUSH_W-1:0]  fill_mask;

  // compaction, keeps fetch order
  always_comb begin
    n_valid      = '0;
    packed_slots = '0;
    for (int i = 0; i < FQ_PUSH_W; i++) begin
      if (fetch_in.valid[i]) begin
        packed_slots[n_valid[1:0]] = fetch_in.slot[i];  // n_valid <= i here
        n_valid = n_valid + 3'd1;
      end
    end
  end

  // flags are nested, the lowest set bit gives the exact free space
  always_comb begin
    free_cap = slot_cnt_t'(FQ_PUSH_W);
    for (int i = FQ_PUSH_W - 1; i >= 1; i--) begin
      if (almost_full[i]) free_cap = slot_cnt_t'(i);
    end
    if (full) free_cap = '0;
  end

  always_comb begin
    for (int i = 0; i < FQ_PUSH_W; i++) begin
      fill_mask[i] = (n_valid > slot_cnt_t'(i));
    end
  end

  // an empty packet is always accepted, except during flush
  assign fetch_accept = !flush && (free_cap >= n_valid);

  assign push      = fetch_accept ? fill_mask : '0;
  assign push_data = packed_slots;

endmodule

/* verilog/fetch_queue.sv */
/*
 * instruction fetch queue
 * fetch packets are compacted and pushed into a 16-entry FIFO, then
 * drained toward dispatch as tagged groups of up to four.
 */
module fetch_queue
  import fq_geom_pkg::*;
  import fq_insn_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  logic       flush,
  input  fetch_pkt_t fetch_in,
  output logic       fetch_accept,
  input  slot_cnt_t  disp_ready_cnt,
  output disp_pkt_t  disp_out
);

  logic [FQ_PUSH_W-1:0]  push;
  insn_t [FQ_PUSH_W-1:0] push_data;
  logic [FQ_POP_W-1:0]   pop;
  insn_t [FQ_POP_W-1:0]  head;
  logic                  full;
  logic [FQ_PUSH_W-1:1]  almost_full;
  logic                  empty;
  logic [FQ_POP_W-1:1]   almost_empty;

  fetch_packer i_fetch_packer (
    .fetch_in     (fetch_in),
    .flush        (flush),
    .full         (full),
    .almost_full  (almost_full),
    .fetch_accept (fetch_accept),
    .push         (push),
    .push_data    (push_data)
  );

  multi_fifo i_multi_fifo (
    .clk          (clk),
    .rst_n        (rst_n),
    .clear        (flush),      // flush drops everything at the edge
    .push         (push),
    .datain       (push_data),
    .pop          (pop),
    .dataout      (head),
    .full         (full),
    .almost_full  (almost_full),
    .empty        (empty),
    .almost_empty (almost_empty)
  );

  dispatch_ctrl i_dispatch_ctrl (
    .clk            (clk),
    .rst_n          (rst_n),
    .flush          (flush),
    .disp_ready_cnt (disp_ready_cnt),
    .empty          (empty),
    .almost_empty   (almost_empty),
    .head           (head),
    .pop            (pop),
    .disp_out       (disp_out)
  );

endmodule

/* verilog/fq_geom_pkg.sv */
/*
 * fetch queue geometry
 * depth, per-cycle slot widths, and the pointer, count and tag types
 * shared by the packer, the FIFO and the dispatch controller.
 */
package fq_geom_pkg;

  localparam int FQ_DEPTH    = 16;  // queue entries
  localparam int FQ_PUSH_W   = 4;   // fetch slots per cycle
  localparam int FQ_POP_W    = 4;   // dispatch slots per cycle
  localparam int FQ_PTR_BITS = 4;
  localparam int FQ_TAG_BITS = 6;

  // read/write pointer, wraps modulo FQ_DEPTH
  typedef logic [FQ_PTR_BITS-1:0] fq_ptr_t;

  // occupancy, 0..16 so one bit wider than a pointer
  typedef logic [FQ_PTR_BITS:0] fq_cnt_t;

  typedef logic [2:0] slot_cnt_t;  // 0..4 slots

  typedef logic [FQ_TAG_BITS-1:0] seq_tag_t;  // wraps modulo 64

endpackage

/* verilog/fq_insn_pkg.sv */
/*
 * instruction format for the fetch queue
 * opcode enum, the 42-bit instruction word and the fetch and
 * dispatch packets that carry up to four of them per cycle.
 */
package fq_insn_pkg;

  import fq_geom_pkg::*;

  typedef enum logic [2:0] {
    OP_ALU,
    OP_LOAD,
    OP_STORE,
    OP_BRANCH,
    OP_JUMP,
    OP_NOP
  } op_e;

  typedef struct packed {
    op_e         op;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [11:0] imm;
    logic [11:0] pc_lo;   // low pc bits, enough to track order in sim
  } insn_t;

  // slots may have gaps in valid
  typedef struct packed {
    logic [FQ_PUSH_W-1:0]  valid;
    insn_t [FQ_PUSH_W-1:0] slot;
  } fetch_pkt_t;

  // valid is always a low thermometer mask
  typedef struct packed {
    logic [FQ_POP_W-1:0]     valid;
    insn_t [FQ_POP_W-1:0]    insn;
    seq_tag_t [FQ_POP_W-1:0] tag;
  } disp_pkt_t;

endpackage

/* verilog/multi_fifo.sv */
/*
 * multi-push / multi-pop FIFO
 * 16 instruction entries; up to four pushes and four pops per cycle.
 * push and pop masks are low thermometer masks and are trusted, so
 * overflow and underflow are prevented upstream. occupancy flags are
 * decoded from the registered count only.
 */
module multi_fifo
  import fq_geom_pkg::*;
  import fq_insn_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  clear,
  input  logic [FQ_PUSH_W-1:0]  push,
  input  insn_t [FQ_PUSH_W-1:0] datain,
  input  logic [FQ_POP_W-1:0]   pop,
  output insn_t [FQ_POP_W-1:0]  dataout,
  output logic                  full,
  output logic [FQ_PUSH_W-1:1]  almost_full,
  output logic                  empty,
  output logic [FQ_POP_W-1:1]   almost_empty
);

  insn_t     mem [FQ_DEPTH];
  fq_ptr_t   wptr;
  fq_ptr_t   rptr;
  fq_cnt_t   count;
  slot_cnt_t push_cnt;
  slot_cnt_t pop_cnt;
  fq_ptr_t   wr_slot [FQ_PUSH_W];  // wptr + i, wrapped
  fq_ptr_t   rd_slot [FQ_POP_W];   // rptr + i, wrapped

  always_comb begin
    push_cnt = '0;
    for (int i = 0; i < FQ_PUSH_W; i++) begin
      push_cnt = push_cnt + slot_cnt_t'(push[i]);
    end
  end

  always_comb begin
    pop_cnt = '0;
    for (int i = 0; i < FQ_POP_W; i++) begin
      pop_cnt = pop_cnt + slot_cnt_t'(pop[i]);
    end
  end

  always_comb begin
    for (int i = 0; i < FQ_PUSH_W; i++) begin
      wr_slot[i] = wptr + fq_ptr_t'(i);
    end
    for (int i = 0; i < FQ_POP_W; i++) begin
      rd_slot[i] = rptr + fq_ptr_t'(i);
    end
  end

  // pointers wrap naturally at 4 bits
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wptr  <= '0;
      rptr  <= '0;
      count <= '0;
    end else if (clear) begin
      wptr  <= '0;
      rptr  <= '0;
      count <= '0;
    end else begin
      wptr  <= wptr + fq_ptr_t'(push_cnt);
      rptr  <= rptr + fq_ptr_t'(pop_cnt);
      count <= count + fq_cnt_t'(push_cnt) - fq_cnt_t'(pop_cnt);
    end
  end

  // storage
  always_ff @(posedge clk) begin
    for (int i = 0; i < FQ_PUSH_W; i++) begin
      if (push[i]) mem[wr_slot[i]] <= datain[i];
    end
  end

  // oldest entries first
  always_comb begin
    for (int i = 0; i < FQ_POP_W; i++) begin
      dataout[i] = mem[rd_slot[i]];
    end
  end

  assign full  = (count == fq_cnt_t'(FQ_DEPTH));
  assign empty = (count == '0);

  always_comb begin
    for (int i = 1; i < FQ_PUSH_W; i++) begin
      almost_full[i] = (int'(count) + i >= FQ_DEPTH);  // i or fewer free
    end
  end

  always_comb begin
    for (int i = 1; i < FQ_POP_W; i++) begin
      almost_empty[i] = (int'(count) <= i);  // i or fewer held
    end
  end

endmodule
